//--- fetch_top.f
+incdir+src
src/fetch_pkg.sv
src/ifu.sv
src/lsu.sv
src/mem_arbiter.sv
src/unified_ram.sv
src/fetch_top.sv
sim/tb_fetch_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch_top testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_fetch_top \
  -f fetch_top.f \
  -o sim_fetch_top

status=0
./obj_dir/sim_fetch_top > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
  echo "simulation FAILED, see sim.log"
  exit 1
fi
echo "simulation passed"

//--- sim/tb_fetch_top.sv
////////////////////////////////////////////////////////////////////////////
// testbench: ram preload over the lsu, table of jump/load/store steps,
// fetch reference model with a delivery monitor, cycle timeout
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "fetch_config.svh"

module tb_fetch_top;

  localparam int PRELOAD = 16;
  localparam int NSTEPS  = 8;
  localparam int LIMIT   = (PRELOAD + NSTEPS) * 40;

  logic               clk;
  logic               rst;
  logic               i_ena;
  logic               i_pc_jmp;
  logic [`XLEN-1:0]   i_pc_jmpaddr;
  fetch_pkg::lsu_op_e i_lsu_op;
  logic [`XLEN-1:0]   i_lsu_addr;
  logic [`XLEN-1:0]   i_lsu_wdata;
  logic [`XLEN-1:0]   o_pc;
  logic [`XLEN-1:0]   o_pc_pred;
  logic [31:0]        o_inst;
  logic               o_fetched;
  logic               o_nocmt;
  logic               o_lsu_done;
  logic [`XLEN-1:0]   o_lsu_rdata;

  // scenario table, one column per array
  logic               st_jmp    [NSTEPS];
  logic [`XLEN-1:0]   st_target [NSTEPS];
  fetch_pkg::lsu_op_e st_op     [NSTEPS];
  logic [`XLEN-1:0]   st_addr   [NSTEPS];
  logic [`XLEN-1:0]   st_wdata  [NSTEPS];
  int                 st_nfetch [NSTEPS];
  int                 st_gap    [NSTEPS];

  // reference model state
  logic [`XLEN-1:0]   model_mem [`MEM_WORDS];
  logic [`XLEN-1:0]   next_pc;
  logic [`XLEN-1:0]   last_pred;
  logic               bubble_pending;
  logic [`XLEN-1:0]   bubble_target;
  logic               jmp_pending;
  logic [`XLEN-1:0]   pend_target;
  logic [`XLEN-1:0]   exp_pc;
  logic [31:0]        exp_inst;
  logic               exp_nocmt;

  int                 errors;
  int                 deliveries;
  int                 cycles;
  int                 err_before;
  integer             seed;
  logic [31:0]        lo_word;
  logic [31:0]        hi_word;

  fetch_top fetch_top_inst (
    .clk          (clk),
    .rst          (rst),
    .i_ena        (i_ena),
    .i_pc_jmp     (i_pc_jmp),
    .i_pc_jmpaddr (i_pc_jmpaddr),
    .i_lsu_op     (i_lsu_op),
    .i_lsu_addr   (i_lsu_addr),
    .i_lsu_wdata  (i_lsu_wdata),
    .o_pc         (o_pc),
    .o_pc_pred    (o_pc_pred),
    .o_inst       (o_inst),
    .o_fetched    (o_fetched),
    .o_nocmt      (o_nocmt),
    .o_lsu_done   (o_lsu_done),
    .o_lsu_rdata  (o_lsu_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] got_v);
    $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp_v, got_v);
    errors++;
  endtask

  task automatic print_result(input string name, input int err_start);
    $display("%s: %s", name, (errors == err_start) ? "ok" : "FAIL");
  endtask

  // instruction half of a model word, picked by pc bit 2
  function automatic logic [31:0] inst_at(input logic [`XLEN-1:0] pc);
    logic [`XLEN-1:0] word;
    word = model_mem[pc[10:3]];
    return pc[2] ? word[63:32] : word[31:0];
  endfunction

  function automatic void set_step(input int s, input logic jmp,
                                   input logic [`XLEN-1:0] tgt_off,
                                   input fetch_pkg::lsu_op_e op,
                                   input logic [`XLEN-1:0] addr_off,
                                   input logic [`XLEN-1:0] wdata,
                                   input int nfetch, input int gap);
    st_jmp[s]    = jmp;
    st_target[s] = `PC_START + tgt_off;
    st_op[s]     = op;
    st_addr[s]   = `PC_START + addr_off;
    st_wdata[s]  = wdata;
    st_nfetch[s] = nfetch;
    st_gap[s]    = gap;
  endfunction

  task automatic store_word(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data);
    i_lsu_op    = fetch_pkg::LSU_STORE;
    i_lsu_addr  = addr;
    i_lsu_wdata = data;
    model_mem[addr[10:3]] = data;
    do begin
      @(posedge clk);
      #1;
      i_lsu_op = fetch_pkg::LSU_NOP;
      if (o_fetched) begin
        $display("t=%0t instruction delivered while fetch is disabled", $time);
        errors++;
      end
    end while (!o_lsu_done);
  endtask

  task automatic run_step(input int s);
    int   seen;
    int   gap_seen;
    int   err_start;
    logic done_seen;
    err_start = errors;
    seen      = 0;
    gap_seen  = 0;
    done_seen = (st_op[s] == fetch_pkg::LSU_NOP);
    // line up with a delivery so the jump meets a settled prediction
    do begin
      @(posedge clk);
      #1;
    end while (!o_fetched);
    if (st_jmp[s]) begin
      i_pc_jmp     = 1'b1;
      i_pc_jmpaddr = st_target[s];
      pend_target  = st_target[s];
      jmp_pending  = 1'b1;
    end
    if (st_op[s] != fetch_pkg::LSU_NOP) begin
      i_lsu_op    = st_op[s];
      i_lsu_addr  = st_addr[s];
      i_lsu_wdata = st_wdata[s];
      if (st_op[s] == fetch_pkg::LSU_STORE) model_mem[st_addr[s][10:3]] = st_wdata[s];
    end
    if (st_gap[s] > 0) begin
      i_ena = 1'b0;
      repeat (st_gap[s]) begin
        @(posedge clk);
        #1;
        i_pc_jmp = 1'b0;
        i_lsu_op = fetch_pkg::LSU_NOP;
        if (o_fetched) gap_seen++;
      end
      if (gap_seen > 1) begin
        $display("t=%0t fetch kept delivering with i_ena low (%0d deliveries)",
                 $time, gap_seen);
        errors++;
      end
      i_ena = 1'b1;
    end
    while (seen < st_nfetch[s] || !done_seen) begin
      @(posedge clk);
      #1;
      i_pc_jmp = 1'b0;
      i_lsu_op = fetch_pkg::LSU_NOP;
      if (o_fetched) seen++;
      if (o_lsu_done) begin
        done_seen = 1'b1;
        if (st_op[s] == fetch_pkg::LSU_LOAD && o_lsu_rdata !== model_mem[st_addr[s][10:3]])
          report_mismatch("o_lsu_rdata", model_mem[st_addr[s][10:3]], o_lsu_rdata);
      end
    end
    print_result($sformatf("step %0d jump=%0b op=%s", s, st_jmp[s], st_op[s].name()),
                 err_start);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // delivery monitor and fetch model
  //////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst && o_fetched) begin
      if (bubble_pending) begin
        exp_pc    = bubble_target;
        exp_inst  = `INST_NOP;
        exp_nocmt = 1'b1;
      end else begin
        exp_pc    = next_pc;
        exp_inst  = inst_at(next_pc);
        exp_nocmt = 1'b0;
      end
      if (o_pc !== exp_pc) report_mismatch("o_pc", exp_pc, o_pc);
      if (o_pc_pred !== exp_pc + 64'd4) report_mismatch("o_pc_pred", exp_pc + 64'd4, o_pc_pred);
      if (o_inst !== exp_inst) report_mismatch("o_inst", {32'd0, exp_inst}, {32'd0, o_inst});
      if (o_nocmt !== exp_nocmt) report_mismatch("o_nocmt", {63'd0, exp_nocmt}, {63'd0, o_nocmt});
      // after a bubble the stream restarts at the target itself
      next_pc        = bubble_pending ? bubble_target : next_pc + 64'd4;
      last_pred      = exp_pc + 64'd4;
      bubble_pending = 1'b0;
      deliveries++;
    end
    if (jmp_pending) begin
      if (pend_target != last_pred) begin
        bubble_pending = 1'b1;
        bubble_target  = pend_target;
      end
      jmp_pending = 1'b0;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run still active after %0d cycles", LIMIT);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    rst            = 1'b1;
    i_ena          = 1'b0;
    i_pc_jmp       = 1'b0;
    i_pc_jmpaddr   = '0;
    i_lsu_op       = fetch_pkg::LSU_NOP;
    i_lsu_addr     = '0;
    i_lsu_wdata    = '0;
    errors         = 0;
    deliveries     = 0;
    seed           = 75070;
    next_pc        = `PC_START;
    last_pred      = `PC_START;
    bubble_pending = 1'b0;
    bubble_target  = '0;
    jmp_pending    = 1'b0;
    pend_target    = '0;

    // jump, target, op, lsu address, store data, deliveries, ena-low cycles
    set_step(0, 1'b0, 64'h00, fetch_pkg::LSU_NOP,   64'h00, 64'h0, 3, 0);
    set_step(1, 1'b1, 64'h40, fetch_pkg::LSU_NOP,   64'h00, 64'h0, 3, 0);
    set_step(2, 1'b1, 64'h4c, fetch_pkg::LSU_NOP,   64'h00, 64'h0, 2, 0);
    set_step(3, 1'b0, 64'h00, fetch_pkg::LSU_LOAD,  64'h08, 64'h0, 2, 0);
    set_step(4, 1'b0, 64'h00, fetch_pkg::LSU_STORE, 64'h10, 64'h00300193_00200113, 2, 0);
    set_step(5, 1'b1, 64'h10, fetch_pkg::LSU_NOP,   64'h00, 64'h0, 4, 0);
    set_step(6, 1'b0, 64'h00, fetch_pkg::LSU_NOP,   64'h00, 64'h0, 2, 12);
    set_step(7, 1'b1, 64'h00, fetch_pkg::LSU_LOAD,  64'h78, 64'h0, 3, 0);

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    err_before = errors;
    if (o_fetched !== 1'b0) report_mismatch("o_fetched", 64'd0, {63'd0, o_fetched});
    if (o_nocmt !== 1'b0) report_mismatch("o_nocmt", 64'd0, {63'd0, o_nocmt});
    if (o_lsu_done !== 1'b0) report_mismatch("o_lsu_done", 64'd0, {63'd0, o_lsu_done});
    print_result("reset", err_before);

    // fetch stays off while the program goes in
    err_before = errors;
    for (int i = 0; i < PRELOAD; i++) begin
      lo_word = $random(seed);
      hi_word = $random(seed);
      if (hi_word == lo_word) hi_word = ~lo_word;
      store_word(`PC_START + 64'(i * 8), {hi_word, lo_word});
    end
    print_result("preload", err_before);

    i_ena = 1'b1;
    for (int s = 0; s < NSTEPS; s++) begin
      run_step(s);
    end

    $display("tests %0d, deliveries checked %0d, errors %0d", NSTEPS + 2, deliveries, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- src/fetch_config.svh
////////////////////////////////////////////////////////////////////////////
// global widths, reset fetch address, nop encoding and ram depth
////////////////////////////////////////////////////////////////////////////

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// address and data width
`define XLEN 64

// first fetch address, low bits land at ram word 0
`define PC_START 64'h0000_0000_8000_0000

// addi x0, x0, 0
`define INST_NOP 32'h0000_0013

// ram depth in 64-bit words
`define MEM_WORDS 256

`endif

//--- src/fetch_pkg.sv
////////////////////////////////////////////////////////////////////////////
// enums shared by the fetch subsystem: bus owner, arbiter state, lsu op
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

  // current holder of the shared memory bus
  typedef enum logic [1:0] {
    OWNER_NONE = 2'd0,
    OWNER_IFU  = 2'd1,
    OWNER_LSU  = 2'd2
  } bus_owner_e;

  // arbiter fsm
  typedef enum logic {
    ARB_IDLE = 1'b0,
    ARB_BUSY = 1'b1
  } arb_state_e;

  // load/store command code
  typedef enum logic [1:0] {
    LSU_NOP   = 2'd0,
    LSU_LOAD  = 2'd1,
    LSU_STORE = 2'd2
  } lsu_op_e;

endpackage

//--- src/fetch_top.sv
////////////////////////////////////////////////////////////////////////////
// fetch subsystem top: ifu, lsu, arbiter and shared ram
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_ena,
  input  logic                i_pc_jmp,
  input  logic [`XLEN-1:0]    i_pc_jmpaddr,
  input  fetch_pkg::lsu_op_e  i_lsu_op,
  input  logic [`XLEN-1:0]    i_lsu_addr,
  input  logic [`XLEN-1:0]    i_lsu_wdata,
  output logic [`XLEN-1:0]    o_pc,
  output logic [`XLEN-1:0]    o_pc_pred,
  output logic [31:0]         o_inst,
  output logic                o_fetched,
  output logic                o_nocmt,
  output logic                o_lsu_done,
  output logic [`XLEN-1:0]    o_lsu_rdata
);

  // fetch master
  logic             if_req;
  logic [`XLEN-1:0] if_addr;
  logic             if_ack;
  logic [`XLEN-1:0] if_rdata;
  // load/store master
  logic             ls_req;
  logic [`XLEN-1:0] ls_addr;
  logic             ls_we;
  logic [`XLEN-1:0] ls_wdata;
  logic             ls_ack;
  logic [`XLEN-1:0] ls_rdata;
  // ram port
  logic             mem_req;
  logic [`XLEN-1:0] mem_addr;
  logic             mem_we;
  logic [`XLEN-1:0] mem_wdata;
  logic             mem_ack;
  logic [`XLEN-1:0] mem_rdata;

  ifu ifu_inst (
    .clk          (clk),
    .rst          (rst),
    .i_ena        (i_ena),
    .i_bus_ack    (if_ack),
    .i_bus_rdata  (if_rdata),
    .o_bus_req    (if_req),
    .o_bus_addr   (if_addr),
    .i_pc_jmp     (i_pc_jmp),
    .i_pc_jmpaddr (i_pc_jmpaddr),
    .o_pc         (o_pc),
    .o_pc_pred    (o_pc_pred),
    .o_inst       (o_inst),
    .o_fetched    (o_fetched),
    .o_nocmt      (o_nocmt)
  );

  lsu lsu_inst (
    .clk          (clk),
    .rst          (rst),
    .i_lsu_op     (i_lsu_op),
    .i_lsu_addr   (i_lsu_addr),
    .i_lsu_wdata  (i_lsu_wdata),
    .i_bus_ack    (ls_ack),
    .i_bus_rdata  (ls_rdata),
    .o_bus_req    (ls_req),
    .o_bus_addr   (ls_addr),
    .o_bus_we     (ls_we),
    .o_bus_wdata  (ls_wdata),
    .o_lsu_done   (o_lsu_done),
    .o_lsu_rdata  (o_lsu_rdata)
  );

  mem_arbiter mem_arbiter_inst (
    .clk          (clk),
    .rst          (rst),
    .i_if_req     (if_req),
    .i_if_addr    (if_addr),
    .o_if_ack     (if_ack),
    .o_if_rdata   (if_rdata),
    .i_ls_req     (ls_req),
    .i_ls_addr    (ls_addr),
    .i_ls_we      (ls_we),
    .i_ls_wdata   (ls_wdata),
    .o_ls_ack     (ls_ack),
    .o_ls_rdata   (ls_rdata),
    .i_mem_ack    (mem_ack),
    .i_mem_rdata  (mem_rdata),
    .o_mem_req    (mem_req),
    .o_mem_addr   (mem_addr),
    .o_mem_we     (mem_we),
    .o_mem_wdata  (mem_wdata)
  );

  unified_ram unified_ram_inst (
    .clk          (clk),
    .rst          (rst),
    .i_mem_req    (mem_req),
    .i_mem_addr   (mem_addr),
    .i_mem_we     (mem_we),
    .i_mem_wdata  (mem_wdata),
    .o_mem_ack    (mem_ack),
    .o_mem_rdata  (mem_rdata)
  );

endmodule

//--- src/ifu.sv
////////////////////////////////////////////////////////////////////////////
// instruction fetch unit: sequential pc, jump compare, flush and bubble
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "fetch_config.svh"

module ifu (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_ena,
  // shared bus master port
  input  logic               i_bus_ack,
  input  logic [`XLEN-1:0]   i_bus_rdata,
  output logic               o_bus_req,
  output logic [`XLEN-1:0]   o_bus_addr,
  // jump feedback from execute
  input  logic               i_pc_jmp,
  input  logic [`XLEN-1:0]   i_pc_jmpaddr,
  // delivered instruction
  output logic [`XLEN-1:0]   o_pc,
  output logic [`XLEN-1:0]   o_pc_pred,
  output logic [31:0]        o_inst,
  output logic               o_fetched,
  output logic               o_nocmt
);

  logic             flush_en;
  logic             drop_once;
  logic [`XLEN-1:0] jmp_target;
  logic             handshake;
  logic             mispredict;
  logic [31:0]      inst_half;

  assign handshake  = o_bus_req & i_bus_ack;
  // a second jump while a flush is pending is ignored
  assign mispredict = i_pc_jmp & ~flush_en & (i_pc_jmpaddr != o_pc_pred);
  // word holds two instructions, pc bit 2 picks one
  assign inst_half  = o_bus_addr[2] ? i_bus_rdata[`XLEN-1:32] : i_bus_rdata[31:0];

  //////////////////////////////////////////////////////////////////////////
  // fetch sequencing
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_req  <= 1'b0;
      o_bus_addr <= `PC_START;
      o_pc       <= '0;
      o_pc_pred  <= `PC_START;
      o_inst     <= `INST_NOP;
      o_fetched  <= 1'b0;
      o_nocmt    <= 1'b0;
      flush_en   <= 1'b0;
      drop_once  <= 1'b0;
    end else begin
      o_fetched <= 1'b0;
      o_nocmt   <= 1'b0;
      if (mispredict) begin
        flush_en  <= 1'b1;
        // drop whatever is outstanding, an ack right now is dropped below
        drop_once <= o_bus_req & ~i_bus_ack;
      end
      if (handshake) begin
        if (mispredict || drop_once) begin
          // stale fetch, hold off until the address is reloaded
          drop_once <= 1'b0;
          o_bus_req <= 1'b0;
        end else begin
          o_bus_req  <= i_ena;
          o_bus_addr <= o_bus_addr + `XLEN'd4;
          o_pc       <= o_bus_addr;
          o_pc_pred  <= o_bus_addr + `XLEN'd4;
          o_inst     <= inst_half;
          o_fetched  <= 1'b1;
        end
      end else if (flush_en && !drop_once) begin
        // uncommitted nop bubble at the jump target
        flush_en   <= 1'b0;
        o_bus_addr <= jmp_target;
        o_bus_req  <= i_ena;
        o_pc       <= jmp_target;
        o_pc_pred  <= jmp_target + `XLEN'd4;
        o_inst     <= `INST_NOP;
        o_nocmt    <= 1'b1;
        o_fetched  <= 1'b1;
      end else if (!o_bus_req && i_ena && !flush_en && !mispredict) begin
        o_bus_req <= 1'b1;
      end
    end
  end

  // jump target held until the bubble goes out
  always_ff @(posedge clk) begin
    if (mispredict) begin
      jmp_target <= i_pc_jmpaddr;
    end
  end

  // discarded fetch must not come out as a delivery
  assert property (@(posedge clk) disable iff (rst)
    (handshake && (drop_once || mispredict)) |=> !o_fetched)
    else $error("ifu: dropped fetch was delivered");

endmodule

//--- src/lsu.sv
////////////////////////////////////////////////////////////////////////////
// load/store unit, one 64-bit command at a time over the shared bus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "fetch_config.svh"

module lsu (
  input  logic                clk,
  input  logic                rst,
  // command strobe
  input  fetch_pkg::lsu_op_e  i_lsu_op,
  input  logic [`XLEN-1:0]    i_lsu_addr,
  input  logic [`XLEN-1:0]    i_lsu_wdata,
  // shared bus master port
  input  logic                i_bus_ack,
  input  logic [`XLEN-1:0]    i_bus_rdata,
  output logic                o_bus_req,
  output logic [`XLEN-1:0]    o_bus_addr,
  output logic                o_bus_we,
  output logic [`XLEN-1:0]    o_bus_wdata,
  // completion
  output logic                o_lsu_done,
  output logic [`XLEN-1:0]    o_lsu_rdata
);

  logic cmd_valid;

  assign cmd_valid = (i_lsu_op != fetch_pkg::LSU_NOP);

  // request stays up until the ack cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      o_bus_req  <= 1'b0;
      o_lsu_done <= 1'b0;
    end else begin
      o_lsu_done <= 1'b0;
      if (o_bus_req) begin
        if (i_bus_ack) begin
          o_bus_req  <= 1'b0;
          o_lsu_done <= 1'b1;
        end
      end else if (cmd_valid) begin
        o_bus_req <= 1'b1;
      end
    end
  end

  // one-entry command register
  always_ff @(posedge clk) begin
    if (!o_bus_req && cmd_valid) begin
      o_bus_addr  <= i_lsu_addr;
      o_bus_we    <= (i_lsu_op == fetch_pkg::LSU_STORE);
      o_bus_wdata <= i_lsu_wdata;
    end
  end

  // load data, stores leave the last value
  always_ff @(posedge clk) begin
    if (o_bus_req && i_bus_ack && !o_bus_we) begin
      o_lsu_rdata <= i_bus_rdata;
    end
  end

  // no back-pressure on the command port
  assert property (@(posedge clk) disable iff (rst)
    cmd_valid |-> !o_bus_req)
    else $error("lsu: command issued while busy");

endmodule

//--- src/mem_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// two-master bus arbiter, lsu priority, grant held until ram ack
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "fetch_config.svh"

module mem_arbiter (
  input  logic               clk,
  input  logic               rst,
  // fetch master
  input  logic               i_if_req,
  input  logic [`XLEN-1:0]   i_if_addr,
  output logic               o_if_ack,
  output logic [`XLEN-1:0]   o_if_rdata,
  // load/store master
  input  logic               i_ls_req,
  input  logic [`XLEN-1:0]   i_ls_addr,
  input  logic               i_ls_we,
  input  logic [`XLEN-1:0]   i_ls_wdata,
  output logic               o_ls_ack,
  output logic [`XLEN-1:0]   o_ls_rdata,
  // ram side
  input  logic               i_mem_ack,
  input  logic [`XLEN-1:0]   i_mem_rdata,
  output logic               o_mem_req,
  output logic [`XLEN-1:0]   o_mem_addr,
  output logic               o_mem_we,
  output logic [`XLEN-1:0]   o_mem_wdata
);

  fetch_pkg::arb_state_e state;
  fetch_pkg::bus_owner_e owner;
  logic                  if_own;
  logic                  ls_own;

  assign if_own = (state == fetch_pkg::ARB_BUSY) && (owner == fetch_pkg::OWNER_IFU);
  assign ls_own = (state == fetch_pkg::ARB_BUSY) && (owner == fetch_pkg::OWNER_LSU);

  //////////////////////////////////////////////////////////////////////////
  // grant fsm
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fetch_pkg::ARB_IDLE;
      owner <= fetch_pkg::OWNER_NONE;
    end else begin
      case (state)
        fetch_pkg::ARB_IDLE: begin
          // lsu wins a tie
          if (i_ls_req) begin
            owner <= fetch_pkg::OWNER_LSU;
            state <= fetch_pkg::ARB_BUSY;
          end else if (i_if_req) begin
            owner <= fetch_pkg::OWNER_IFU;
            state <= fetch_pkg::ARB_BUSY;
          end
        end
        fetch_pkg::ARB_BUSY: begin
          if (i_mem_ack) begin
            owner <= fetch_pkg::OWNER_NONE;
            state <= fetch_pkg::ARB_IDLE;
          end
        end
        default: begin
          state <= fetch_pkg::ARB_IDLE;
        end
      endcase
    end
  end

  // forward owner to ram
  assign o_mem_req   = (ls_own & i_ls_req) | (if_own & i_if_req);
  assign o_mem_addr  = ls_own ? i_ls_addr : i_if_addr;
  assign o_mem_we    = ls_own & i_ls_we;
  assign o_mem_wdata = i_ls_wdata;

  // response only to the owner
  assign o_if_ack   = if_own & i_mem_ack;
  assign o_ls_ack   = ls_own & i_mem_ack;
  assign o_if_rdata = if_own ? i_mem_rdata : '0;
  assign o_ls_rdata = ls_own ? i_mem_rdata : '0;

  assert property (@(posedge clk) disable iff (rst)
    (state == fetch_pkg::ARB_BUSY) |-> (owner != fetch_pkg::OWNER_NONE))
    else $error("arbiter: busy without an owner");

  assert property (@(posedge clk) disable iff (rst)
    !(o_if_ack && o_ls_ack))
    else $error("arbiter: both masters acknowledged");

endmodule

//--- src/unified_ram.sv
////////////////////////////////////////////////////////////////////////////
// word-addressed ram, shared by fetch and load/store
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "fetch_config.svh"

module unified_ram (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_mem_req,
  input  logic [`XLEN-1:0]   i_mem_addr,
  input  logic               i_mem_we,
  input  logic [`XLEN-1:0]   i_mem_wdata,
  output logic               o_mem_ack,
  output logic [`XLEN-1:0]   o_mem_rdata
);

  localparam int AW = $clog2(`MEM_WORDS);

  logic [`XLEN-1:0] mem [`MEM_WORDS];
  logic [AW-1:0]    word_idx;
  logic             serve;

  // 8-byte words, bits [2:0] are the byte offset
  assign word_idx = i_mem_addr[3 +: AW];

  // request still high in its own ack cycle is not a new one
  assign serve = i_mem_req & ~o_mem_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_mem_ack <= 1'b0;
    end else begin
      o_mem_ack <= serve;
    end
  end

  // read and write share the same edge
  always_ff @(posedge clk) begin
    if (serve) begin
      if (i_mem_we) begin
        mem[word_idx] <= i_mem_wdata;
      end
      o_mem_rdata <= mem[word_idx];
    end
  end

  // master keeps the address through the ack
  assert property (@(posedge clk) disable iff (rst)
    serve |=> $stable(i_mem_addr))
    else $error("ram: address changed before ack");

endmodule
